// File: include/tangent_consts.svh
`ifndef TANGENT_CONSTS_SVH
`define TANGENT_CONSTS_SVH

// Signed Q16.16 value width
`define TSF_COORD_W 32

// Fraction bits of the Q16.16 format
`define TSF_FRAC_W 16

// One subtraction lane per vector component
`define TSF_LANES 3

// edge1, edge2, UV delta 1, UV delta 2
`define TSF_JOBS 4

// Request to response, in cycles
`define TSF_LANE_LAT 2

// Enough to number every job of a frame
`define TSF_TAG_W 2

`endif

// File: design/tangent_pkg.sv
`include "tangent_consts.svh"

package tangent_pkg;

    typedef logic signed [`TSF_COORD_W-1:0] coord_t;  // Q16.16
    typedef logic [`TSF_TAG_W-1:0] job_tag_t;           // 0 edge1, 1 edge2, 2 duv1, 3 duv2

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;

    typedef struct packed {
        vec3_t v0;
        vec3_t v1;
        vec3_t v2;
    } tri_t;

    typedef struct packed {
        coord_t u;
        coord_t v;
    } uv_t;

    typedef struct packed {
        uv_t uv0;
        uv_t uv1;
        uv_t uv2;
    } uv_set_t;

    typedef struct packed {
        coord_t du1;
        coord_t dv1;
        coord_t du2;
        coord_t dv2;
    } duv_t;

    // Row-major, element 0 in the top bits
    typedef struct packed {
        coord_t m00;
        coord_t m01;
        coord_t m02;
        coord_t m10;
        coord_t m11;
        coord_t m12;
        coord_t m20;
        coord_t m21;
        coord_t m22;
    } mat3_t;

    typedef struct packed {
        logic     valid;
        job_tag_t tag;
        coord_t   a;     // Minuend
        coord_t   b;     // Subtrahend
    } lane_req_t;

    typedef struct packed {
        logic     valid;
        job_tag_t tag;
        coord_t   diff;
        logic     sat;
    } lane_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DONE_WAIT
    } dispatch_state_t;

endpackage

// File: design/sub_lane.sv
`include "tangent_consts.svh"

module sub_lane (
    input  logic                   clk,
    input  logic                   rst_n,
    input  tangent_pkg::lane_req_t i_req,
    output tangent_pkg::lane_rsp_t o_rsp
);

    logic                    s1_valid;
    tangent_pkg::job_tag_t   s1_tag;
    logic [`TSF_COORD_W:0]   s1_diff;      // One guard bit above the sign
    logic [`TSF_COORD_W:0]   wide_a;
    logic [`TSF_COORD_W:0]   wide_b;
    logic [`TSF_COORD_W:0]   wide_diff;
    logic                    s1_ovf;
    tangent_pkg::coord_t     clamped;

    // Sign extension keeps the true difference representable
    assign wide_a    = {i_req.a[`TSF_COORD_W-1], i_req.a};
    assign wide_b    = {i_req.b[`TSF_COORD_W-1], i_req.b};
    assign wide_diff = wide_a - wide_b;

    // Guard and sign bit differ only when the result left the coord_t range
    assign s1_ovf = s1_diff[`TSF_COORD_W] ^ s1_diff[`TSF_COORD_W-1];

    always_comb begin
        if (!s1_ovf) begin
            clamped = s1_diff[`TSF_COORD_W-1:0];
        end else if (s1_diff[`TSF_COORD_W]) begin
            clamped = {1'b1, {(`TSF_COORD_W-1){1'b0}}};   // Negative overflow
        end else begin
            clamped = {1'b0, {(`TSF_COORD_W-1){1'b1}}};   // Positive overflow
        end
    end

    always_ff @(posedge clk) begin
        // Stage 1 widened subtract
        s1_tag  <= i_req.tag;
        s1_diff <= wide_diff;

        // Stage 2 clamp and flag
        o_rsp.tag  <= s1_tag;
        o_rsp.diff <= clamped;
        o_rsp.sat  <= s1_ovf;

        if (!rst_n) begin
            s1_valid    <= 1'b0;
            o_rsp.valid <= 1'b0;
        end else begin
            s1_valid    <= i_req.valid;
            o_rsp.valid <= s1_valid;
        end
    end

    // Fixed latency, no stall and no dropped job
    a_lat_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        i_req.valid |-> ##`TSF_LANE_LAT o_rsp.valid);

    a_lat_bwd: assert property (@(posedge clk) disable iff (!rst_n)
        o_rsp.valid |-> $past(i_req.valid, `TSF_LANE_LAT));

endmodule

// File: design/operand_dispatch.sv
`include "tangent_consts.svh"

module operand_dispatch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_data_valid,
    input  tangent_pkg::tri_t      i_view_tri,
    input  tangent_pkg::uv_set_t   i_uv,
    input  tangent_pkg::vec3_t     i_bn,
    input  logic                   i_calc_done,
    input  logic                   i_read_done,
    output logic                   o_ready,
    output tangent_pkg::lane_req_t o_req [`TSF_LANES],
    output tangent_pkg::vec3_t     o_bn,
    output logic                   o_clear
);

    tangent_pkg::dispatch_state_t state;
    tangent_pkg::job_tag_t        job_cnt;
    tangent_pkg::tri_t            tri_q;
    tangent_pkg::uv_set_t         uv_q;
    tangent_pkg::lane_req_t       req_next [`TSF_LANES];
    logic [`TSF_LANES-1:0]        req_valid;
    logic                         accept;

    function automatic tangent_pkg::lane_req_t mk_req(
        input tangent_pkg::job_tag_t tag,
        input tangent_pkg::coord_t   a,
        input tangent_pkg::coord_t   b
    );
        tangent_pkg::lane_req_t r;
        r.valid = 1'b1;
        r.tag   = tag;
        r.a     = a;
        r.b     = b;
        return r;
    endfunction

    assign o_ready = (state == tangent_pkg::IDLE);
    assign accept  = o_ready && i_data_valid;   // Strobes while busy are dropped

    // Read strobe counts only once the collector holds a full frame
    assign o_clear = (state == tangent_pkg::DONE_WAIT) && i_calc_done && i_read_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= tangent_pkg::IDLE;
            job_cnt <= '0;
        end else begin
            case (state)
                tangent_pkg::IDLE: begin
                    if (accept) begin
                        state   <= tangent_pkg::ISSUE;
                        job_cnt <= '0;
                    end
                end
                tangent_pkg::ISSUE: begin
                    job_cnt <= job_cnt + 1'b1;
                    if (job_cnt == tangent_pkg::job_tag_t'(`TSF_JOBS - 1)) begin
                        state <= tangent_pkg::DONE_WAIT;
                    end
                end
                tangent_pkg::DONE_WAIT: begin
                    if (o_clear) begin
                        state <= tangent_pkg::IDLE;
                    end
                end
                default: state <= tangent_pkg::IDLE;
            endcase
        end
    end

    // Frame operands, held until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            tri_q <= i_view_tri;
            uv_q  <= i_uv;
            o_bn  <= i_bn;
        end
    end

    always_comb begin
        for (int l = 0; l < `TSF_LANES; l++) begin
            req_next[l] = '0;
        end
        if (state == tangent_pkg::ISSUE) begin
            case (job_cnt)
                2'd0: begin  // edge1 = v1 - v0
                    req_next[0] = mk_req(job_cnt, tri_q.v1.x, tri_q.v0.x);
                    req_next[1] = mk_req(job_cnt, tri_q.v1.y, tri_q.v0.y);
                    req_next[2] = mk_req(job_cnt, tri_q.v1.z, tri_q.v0.z);
                end
                2'd1: begin  // edge2 = v2 - v0
                    req_next[0] = mk_req(job_cnt, tri_q.v2.x, tri_q.v0.x);
                    req_next[1] = mk_req(job_cnt, tri_q.v2.y, tri_q.v0.y);
                    req_next[2] = mk_req(job_cnt, tri_q.v2.z, tri_q.v0.z);
                end
                2'd2: begin
                    req_next[0] = mk_req(job_cnt, uv_q.uv1.u, uv_q.uv0.u);
                    req_next[1] = mk_req(job_cnt, uv_q.uv1.v, uv_q.uv0.v);
                end
                default: begin  // Last job, UV delta of vertex 2
                    req_next[0] = mk_req(job_cnt, uv_q.uv2.u, uv_q.uv0.u);
                    req_next[1] = mk_req(job_cnt, uv_q.uv2.v, uv_q.uv0.v);
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int l = 0; l < `TSF_LANES; l++) begin
                o_req[l].valid <= 1'b0;
            end
        end else begin
            o_req <= req_next;
        end
    end

    always_comb begin
        for (int l = 0; l < `TSF_LANES; l++) begin
            req_valid[l] = o_req[l].valid;
        end
    end

    // Registered requests trail the ISSUE state by one cycle
    a_req_in_issue: assert property (@(posedge clk) disable iff (!rst_n)
        |req_valid |-> $past(state) == tangent_pkg::ISSUE);

endmodule

// File: design/result_collect.sv
`include "tangent_consts.svh"

module result_collect (
    input  logic                   clk,
    input  logic                   rst_n,
    input  tangent_pkg::lane_rsp_t i_rsp [`TSF_LANES],
    input  tangent_pkg::vec3_t     i_bn,
    input  logic                   i_clear,
    output tangent_pkg::mat3_t     o_ai_matrix,
    output tangent_pkg::duv_t      o_duv,
    output logic                   o_sat,
    output logic                   o_calc_done
);

    tangent_pkg::coord_t  edge1_q [`TSF_LANES];   // x, y, z
    tangent_pkg::coord_t  edge2_q [`TSF_LANES];
    tangent_pkg::coord_t  duv_q   [4];            // du1, dv1, du2, dv2
    logic [`TSF_JOBS-1:0] rcvd_q;
    logic [`TSF_JOBS-1:0] rcvd_next;
    logic                 sat_next;

    // Lane index is the vector component, tag picks the slot
    always_ff @(posedge clk) begin
        for (int l = 0; l < `TSF_LANES; l++) begin
            if (i_rsp[l].valid) begin
                case (i_rsp[l].tag)
                    2'd0: edge1_q[l] <= i_rsp[l].diff;
                    2'd1: edge2_q[l] <= i_rsp[l].diff;
                    2'd2: begin
                        if (l < 2) begin
                            duv_q[l] <= i_rsp[l].diff;
                        end
                    end
                    default: begin
                        if (l < 2) begin
                            duv_q[l + 2] <= i_rsp[l].diff;
                        end
                    end
                endcase
            end
        end
    end

    always_comb begin
        rcvd_next = rcvd_q;
        sat_next  = o_sat;
        for (int l = 0; l < `TSF_LANES; l++) begin
            if (i_rsp[l].valid) begin
                rcvd_next[i_rsp[l].tag] = 1'b1;
                sat_next                = sat_next | i_rsp[l].sat;  // Sticky per frame
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || i_clear) begin
            rcvd_q      <= '0;
            o_sat       <= 1'b0;
            o_calc_done <= 1'b0;
        end else begin
            rcvd_q      <= rcvd_next;
            o_sat       <= sat_next;
            o_calc_done <= &rcvd_next;  // Rises with the last job's write
        end
    end

    // Columns are edge1, edge2 and the normal
    always_comb begin
        o_ai_matrix.m00 = edge1_q[0];
        o_ai_matrix.m01 = edge2_q[0];
        o_ai_matrix.m02 = i_bn.x;
        o_ai_matrix.m10 = edge1_q[1];
        o_ai_matrix.m11 = edge2_q[1];
        o_ai_matrix.m12 = i_bn.y;
        o_ai_matrix.m20 = edge1_q[2];
        o_ai_matrix.m21 = edge2_q[2];
        o_ai_matrix.m22 = i_bn.z;
    end

    always_comb begin
        o_duv.du1 = duv_q[0];
        o_duv.dv1 = duv_q[1];
        o_duv.du2 = duv_q[2];
        o_duv.dv2 = duv_q[3];
    end

    // Lanes of one job arrive together, a repeat on a later cycle is stale
    for (genvar l = 0; l < `TSF_LANES; l++) begin : gen_chk
        a_no_dup_tag: assert property (@(posedge clk) disable iff (!rst_n || i_clear)
            i_rsp[l].valid |-> !rcvd_q[i_rsp[l].tag]);
    end

endmodule

// File: design/tangent_frame_front.sv
`include "tangent_consts.svh"

module tangent_frame_front (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_data_valid,
    output logic                 o_ready,
    input  tangent_pkg::tri_t    i_view_tri,
    input  tangent_pkg::uv_set_t i_uv,
    input  tangent_pkg::vec3_t   i_bn,
    output logic                 o_calc_done,
    input  logic                 i_read_done,
    output tangent_pkg::mat3_t   o_ai_matrix,
    output tangent_pkg::duv_t    o_duv,
    output logic                 o_sat
);

    tangent_pkg::lane_req_t lane_req [`TSF_LANES];
    tangent_pkg::lane_rsp_t lane_rsp [`TSF_LANES];
    tangent_pkg::vec3_t     bn_q;        // Normal captured with the frame
    logic                   clear;

    operand_dispatch operand_dispatch_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_data_valid (i_data_valid),
        .i_view_tri   (i_view_tri),
        .i_uv         (i_uv),
        .i_bn         (i_bn),
        .i_calc_done  (o_calc_done),
        .i_read_done  (i_read_done),
        .o_ready      (o_ready),
        .o_req        (lane_req),
        .o_bn         (bn_q),
        .o_clear      (clear)
    );

    // One lane per vector component
    for (genvar l = 0; l < `TSF_LANES; l++) begin : gen_lane
        sub_lane sub_lane_i (
            .clk   (clk),
            .rst_n (rst_n),
            .i_req (lane_req[l]),
            .o_rsp (lane_rsp[l])
        );
    end

    result_collect result_collect_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_rsp       (lane_rsp),
        .i_bn        (bn_q),
        .i_clear     (clear),
        .o_ai_matrix (o_ai_matrix),
        .o_duv       (o_duv),
        .o_sat       (o_sat),
        .o_calc_done (o_calc_done)
    );

endmodule

// File: tb/tangent_frame_front_tb.sv
`include "tangent_consts.svh"

module tangent_frame_front_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FRAMES = 8;
    localparam int WAIT_LIMIT = 50;                          // Cycles per wait
    localparam logic signed [`TSF_COORD_W:0] COORD_MAX = 33'sh0_7fff_ffff;
    localparam logic signed [`TSF_COORD_W:0] COORD_MIN = 33'sh1_8000_0000;

    logic                  clk;
    logic                  rst_n;
    logic                  i_data_valid;
    logic                  o_ready;
    tangent_pkg::tri_t     i_view_tri;
    tangent_pkg::uv_set_t  i_uv;
    tangent_pkg::vec3_t    i_bn;
    logic                  o_calc_done;
    logic                  i_read_done;
    tangent_pkg::mat3_t    o_ai_matrix;
    tangent_pkg::duv_t     o_duv;
    logic                  o_sat;

    // Stimulus table with one row per frame
    tangent_pkg::tri_t    tri_tab [NUM_FRAMES];
    tangent_pkg::uv_set_t uv_tab  [NUM_FRAMES];
    tangent_pkg::vec3_t   bn_tab  [NUM_FRAMES];
    int                   hold_tab [NUM_FRAMES] = '{0, 3, 0, 2, 0, 1, 4, 0};  // Reader delay

    tangent_pkg::mat3_t   exp_mat;
    tangent_pkg::duv_t    exp_duv;
    logic                 exp_sat;
    logic [31:0]          lcg_state = 32'ha873f45c;

    tangent_frame_front tangent_frame_front_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_data_valid (i_data_valid),
        .o_ready      (o_ready),
        .i_view_tri   (i_view_tri),
        .i_uv         (i_uv),
        .i_bn         (i_bn),
        .o_calc_done  (o_calc_done),
        .i_read_done  (i_read_done),
        .o_ai_matrix  (o_ai_matrix),
        .o_duv        (o_duv),
        .o_sat        (o_sat)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic tangent_pkg::vec3_t mk_vec(input logic [31:0] x, y, z);
        return {x, y, z};
    endfunction

    // Clamp a true 33-bit difference into Q16.16
    function automatic tangent_pkg::coord_t saturate(input logic signed [`TSF_COORD_W:0] wide,
                                                     output logic ovf);
        ovf = 1'b0;
        if (wide > COORD_MAX) begin
            ovf = 1'b1;
            return 32'h7fff_ffff;
        end
        if (wide < COORD_MIN) begin
            ovf = 1'b1;
            return 32'h8000_0000;
        end
        return wide[`TSF_COORD_W-1:0];
    endfunction

    task automatic expect_sub(input tangent_pkg::coord_t a, input tangent_pkg::coord_t b,
                              output tangent_pkg::coord_t d);
        logic signed [`TSF_COORD_W:0] wide;
        logic                         ovf;
        wide    = a - b;    // Signed operands widen to the 33-bit result
        d       = saturate(wide, ovf);
        exp_sat = exp_sat | ovf;
    endtask

    task automatic compute_expected(input int f);
        tangent_pkg::tri_t    t;
        tangent_pkg::uv_set_t u;
        t       = tri_tab[f];
        u       = uv_tab[f];
        exp_sat = 1'b0;
        expect_sub(t.v1.x, t.v0.x, exp_mat.m00);
        expect_sub(t.v2.x, t.v0.x, exp_mat.m01);
        exp_mat.m02 = bn_tab[f].x;
        expect_sub(t.v1.y, t.v0.y, exp_mat.m10);
        expect_sub(t.v2.y, t.v0.y, exp_mat.m11);
        exp_mat.m12 = bn_tab[f].y;
        expect_sub(t.v1.z, t.v0.z, exp_mat.m20);
        expect_sub(t.v2.z, t.v0.z, exp_mat.m21);
        exp_mat.m22 = bn_tab[f].z;
        expect_sub(u.uv1.u, u.uv0.u, exp_duv.du1);
        expect_sub(u.uv1.v, u.uv0.v, exp_duv.dv1);
        expect_sub(u.uv2.u, u.uv0.u, exp_duv.du2);
        expect_sub(u.uv2.v, u.uv0.v, exp_duv.dv2);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [287:0] got,
                               input logic [287:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopping on first error");
        end
    endtask

    // Full result check while a frame is held
    task automatic check_outputs();
        for (int k = 0; k < 9; k++) begin
            check_value($sformatf("o_ai_matrix[%0d]", k),
                        o_ai_matrix[(8-k)*32 +: 32], exp_mat[(8-k)*32 +: 32]);
        end
        for (int k = 0; k < 4; k++) begin
            check_value($sformatf("o_duv[%0d]", k), o_duv[(3-k)*32 +: 32],
                        exp_duv[(3-k)*32 +: 32]);
        end
        check_value("o_sat", o_sat, exp_sat);
        check_value("o_calc_done", o_calc_done, 1'b1);
        check_value("o_ready", o_ready, 1'b0);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        @(negedge clk);
        while (o_calc_done !== 1'b1) begin
            n++;
            if (n > WAIT_LIMIT) abort_run("o_calc_done never rose after a frame was accepted");
            @(negedge clk);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (o_calc_done !== 1'b0 || o_ready !== 1'b1) begin
            n++;
            if (n > WAIT_LIMIT) abort_run("design did not return to ready after read_done");
            @(negedge clk);
        end
    endtask

    task automatic fill_table();
        // All zero
        tri_tab[0] = '0;
        uv_tab[0]  = '0;
        bn_tab[0]  = '0;
        // Positive and negative overflow on edges and UV deltas
        tri_tab[1] = {mk_vec(32'h8000_0000, 32'h7fff_ffff, 32'h0001_0000),
                      mk_vec(32'h7fff_ffff, 32'h8000_0000, 32'h0002_0000),
                      mk_vec(32'h0000_0000, 32'hffff_0000, 32'h8000_0000)};
        uv_tab[1]  = {32'h7fff_0000, 32'h8001_0000, 32'h8000_0000, 32'h7fff_0000,
                      32'h0000_0000, 32'h0000_0000};
        bn_tab[1]  = mk_vec(32'h0001_0000, 32'h0000_0000, 32'h0000_0000);
        tri_tab[2] = {mk_vec(32'h0001_0000, 32'h0002_0000, 32'h0003_0000),
                      mk_vec(32'h0004_8000, 32'hfffe_c000, 32'h0003_0000),
                      mk_vec(32'hfffe_0000, 32'h0000_8000, 32'h000a_0000)};
        uv_tab[2]  = {32'h0, 32'h0, 32'h0001_0000, 32'h0, 32'h0, 32'h0001_0000};
        bn_tab[2]  = mk_vec(32'h0, 32'h0, 32'h0001_0000);
        tri_tab[3] = {mk_vec(32'h0000_4000, 32'hffff_c000, 32'h1234_5678),
                      mk_vec(32'h0000_0001, 32'h0000_0002, 32'h1234_5679),
                      mk_vec(32'hffff_ffff, 32'h7fff_0000, 32'hedcb_a988)};
        uv_tab[3]  = {32'h0000_8000, 32'h0000_8000, 32'h0000_c000, 32'h0000_4000,
                      32'h0000_0000, 32'h0001_0000};
        bn_tab[3]  = mk_vec(32'h0000_b505, 32'h0000_b505, 32'h0);
        // Differences that land exactly on the range ends
        tri_tab[4] = {mk_vec(32'hc000_0000, 32'h3fff_ffff, 32'h0000_0000),
                      mk_vec(32'h3fff_ffff, 32'hc000_0000, 32'h7fff_ffff),
                      mk_vec(32'h8000_0000, 32'h7fff_ffff, 32'h8000_0000)};
        uv_tab[4]  = {32'h0000_0001, 32'h0000_0002, 32'h7fff_ffff, 32'h0000_0000,
                      32'h0000_0000, 32'h8000_0002};
        bn_tab[4]  = mk_vec(32'hffff_0000, 32'h0001_0000, 32'h8000_0000);
        tri_tab[5] = {mk_vec(32'h0010_0000, 32'h0020_0000, 32'h0030_0000),
                      mk_vec(32'h000f_0000, 32'h0021_8000, 32'h0030_0000),
                      mk_vec(32'h0011_0000, 32'h001f_0000, 32'h0031_0000)};
        uv_tab[5]  = {32'h0000_1000, 32'h0000_2000, 32'h0000_2000, 32'h0000_1000,
                      32'h0000_3000, 32'h0000_3000};
        bn_tab[5]  = mk_vec(32'h0, 32'h0001_0000, 32'h0);
        for (int f = 6; f < NUM_FRAMES; f++) begin
            for (int k = 0; k < 9; k++) begin
                lcg_state            = lcg_next(lcg_state);
                tri_tab[f][k*32 +: 32] = lcg_state;
            end
            for (int k = 0; k < 6; k++) begin
                lcg_state             = lcg_next(lcg_state);
                uv_tab[f][k*32 +: 32] = lcg_state;
            end
            for (int k = 0; k < 3; k++) begin
                lcg_state             = lcg_next(lcg_state);
                bn_tab[f][k*32 +: 32] = lcg_state;
            end
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        i_data_valid = 1'b0;
        i_read_done  = 1'b0;
        i_view_tri   = '0;
        i_uv         = '0;
        i_bn         = '0;
        fill_table();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("o_ready", o_ready, 1'b1);
        check_value("o_calc_done", o_calc_done, 1'b0);
        check_value("o_sat", o_sat, 1'b0);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            compute_expected(f);
            @(posedge clk);
            i_data_valid <= 1'b1;
            i_view_tri   <= tri_tab[f];
            i_uv         <= uv_tab[f];
            i_bn         <= bn_tab[f];
            @(posedge clk);
            i_data_valid <= 1'b0;
            wait_done();
            check_outputs();

            // Slow reader sees a stray strobe of other data
            for (int h = 0; h < hold_tab[f]; h++) begin
                @(posedge clk);
                i_data_valid <= (h == 0);
                i_view_tri   <= ~tri_tab[f];
                i_uv         <= ~uv_tab[f];
                i_bn         <= ~bn_tab[f];
                @(negedge clk);
                check_outputs();
            end

            @(posedge clk);
            i_data_valid <= 1'b0;
            i_read_done  <= 1'b1;
            @(posedge clk);
            i_read_done  <= 1'b0;
            wait_idle();
            check_value("o_sat", o_sat, 1'b0);   // Cleared with the frame
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
design/tangent_pkg.sv
design/sub_lane.sv
design/operand_dispatch.sv
design/result_collect.sv
design/tangent_frame_front.sv
tb/tangent_frame_front_tb.sv
